// File: src/axi_wr_fifo_pkg.sv
// AXI write packet FIFO types
package axi_wr_fifo_pkg;

   // channel field widths
   localparam int ID_W   = 4;
   localparam int ADDR_W = 32;
   // burst length field holds beats minus one
   localparam int LEN_W  = 8;
   localparam int DATA_W = 32;

   // address and response queue entries
   localparam int AW_DEPTH  = 4;
   // packet store size in beats
   localparam int PKT_DEPTH = 64;

   // one write address command, 44 bits
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
   } aw_cmd_t;

   // one data beat, 33 bits
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } w_beat_t;

   // standard AXI response codes
   typedef enum logic [1:0] {
      okay   = 2'b00,
      exokay = 2'b01,
      slverr = 2'b10,
      decerr = 2'b11
   } bresp_e;

   // one write response, 6 bits
   typedef struct packed {
      logic [ID_W-1:0] id;
      bresp_e          resp;
   } b_rsp_t;

   // address release FSM
   typedef enum logic [1:0] {
      rel_idle = 2'b00,
      rel_addr = 2'b01,
      rel_data = 2'b10
   } release_state_e;

endpackage

// File: src/sync_fifo.sv
// Single clock valid/ready FIFO
`timescale 1ns/1ps
module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  logic             axi_aclk,
   input  logic             reset,
   input  logic [WIDTH-1:0] push_data,
   input  logic             push_valid,
   output logic             push_ready,
   output logic [WIDTH-1:0] pop_data,
   output logic             pop_valid,
   input  logic             pop_ready
);
   // pointer width kept at one bit minimum for a single entry
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [WIDTH-1:0]           mem [DEPTH];
   logic [PTR_W-1:0]           wr_ptr;
   logic [PTR_W-1:0]           rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic                       push_fire;
   logic                       pop_fire;

   // full blocks the push side, empty hides the head
   assign push_ready = (count != DEPTH);
   assign pop_valid  = (count != 0);
   assign pop_data   = mem[rd_ptr];
   assign push_fire  = push_valid && push_ready;
   assign pop_fire   = pop_valid && pop_ready;

   // storage array
   always_ff @(posedge axi_aclk) begin
      if (push_fire) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers wrap at DEPTH so any depth works
   always_ff @(posedge axi_aclk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_fire) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop_fire) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // occupancy holds when both sides fire
         if (push_fire && !pop_fire) begin
            count <= count + 1'b1;
         end else if (pop_fire && !push_fire) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// File: src/wr_packet_store.sv
// Write data packet store
`timescale 1ns/1ps
module wr_packet_store (
   input  logic                     axi_aclk,
   input  logic                     reset,
   input  axi_wr_fifo_pkg::w_beat_t s_w,
   input  logic                     s_wvalid,
   output logic                     s_wready,
   output axi_wr_fifo_pkg::w_beat_t rd_beat,
   output logic                     rd_valid,
   input  logic                     rd_ready,
   output logic                     pkt_avail
);
   import axi_wr_fifo_pkg::*;

   // beat memory
   w_beat_t                        mem [PKT_DEPTH];
   logic [$clog2(PKT_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(PKT_DEPTH)-1:0]   rd_ptr;
   // beats held, full or partial bursts
   logic [$clog2(PKT_DEPTH+1)-1:0] beat_cnt;
   // complete bursts held
   logic [$clog2(PKT_DEPTH+1)-1:0] pkt_cnt;
   logic                           wr_fire;
   logic                           rd_fire;
   logic                           wr_last;
   logic                           rd_last;

   // upstream stalls only on a full store
   assign s_wready = (beat_cnt != PKT_DEPTH);
   assign wr_fire  = s_wvalid && s_wready;

   // head beat always offered
   // the release FSM gates reads to completed bursts
   assign rd_valid = (beat_cnt != 0);
   assign rd_beat  = mem[rd_ptr];
   assign rd_fire  = rd_valid && rd_ready;

   // burst boundaries on each side
   assign wr_last  = wr_fire && s_w.last;
   assign rd_last  = rd_fire && rd_beat.last;

   // at least one whole burst waiting
   assign pkt_avail = (pkt_cnt != 0);

   // payload memory write
   always_ff @(posedge axi_aclk) begin
      if (wr_fire) begin
         mem[wr_ptr] <= s_w;
      end
   end

   // write and read pointers
   always_ff @(posedge axi_aclk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_fire) begin
            wr_ptr <= (wr_ptr == PKT_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_fire) begin
            rd_ptr <= (rd_ptr == PKT_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   // beat occupancy
   always_ff @(posedge axi_aclk) begin
      if (reset) begin
         beat_cnt <= '0;
      end else begin
         case ({wr_fire, rd_fire})
            2'b10:   beat_cnt <= beat_cnt + 1'b1;
            2'b01:   beat_cnt <= beat_cnt - 1'b1;
            default: beat_cnt <= beat_cnt;
         endcase
      end
   end

   // completed burst count
   // up on a stored last beat, down on a read last beat
   always_ff @(posedge axi_aclk) begin
      if (reset) begin
         pkt_cnt <= '0;
      end else begin
         case ({wr_last, rd_last})
            2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
            2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
            default: pkt_cnt <= pkt_cnt;
         endcase
      end
   end

endmodule

// File: src/aw_release_gen.sv
// Write address release FSM
`timescale 1ns/1ps
module aw_release_gen (
   input  logic                     axi_aclk,
   input  logic                     reset,
   input  axi_wr_fifo_pkg::aw_cmd_t q_aw,
   input  logic                     q_awvalid,
   output logic                     q_awready,
   input  logic                     pkt_avail,
   input  axi_wr_fifo_pkg::w_beat_t rd_beat,
   input  logic                     rd_valid,
   output logic                     rd_ready,
   output axi_wr_fifo_pkg::aw_cmd_t m_aw,
   output logic                     m_awvalid,
   input  logic                     m_awready,
   output axi_wr_fifo_pkg::w_beat_t m_w,
   output logic                     m_wvalid,
   input  logic                     m_wready
);
   import axi_wr_fifo_pkg::*;

   release_state_e state;
   release_state_e state_nxt;
   // address held while it waits downstream
   aw_cmd_t        aw_hold;

   // take an address only when its burst is fully stored
   assign q_awready = (state == rel_idle) && pkt_avail;

   assign m_aw      = aw_hold;
   assign m_awvalid = (state == rel_addr);

   // data valve
   // open only after the address handshake
   assign m_w       = rd_beat;
   assign m_wvalid  = (state == rel_data) && rd_valid;
   assign rd_ready  = (state == rel_data) && m_wready;

   always_comb begin
      state_nxt = state;
      case (state)
         rel_idle: begin
            if (q_awvalid && q_awready) begin
               state_nxt = rel_addr;
            end
         end
         rel_addr: begin
            if (m_awready) begin
               state_nxt = rel_data;
            end
         end
         rel_data: begin
            // burst closes on its last beat
            if (m_wvalid && m_wready && rd_beat.last) begin
               state_nxt = rel_idle;
            end
         end
         default: state_nxt = rel_idle;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (reset) begin
         state <= rel_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // capture the popped command
   always_ff @(posedge axi_aclk) begin
      if (q_awvalid && q_awready) begin
         aw_hold <= q_aw;
      end
   end

endmodule

// File: src/axi_wr_packet_fifo.sv
// AXI write packet FIFO top
`timescale 1ns/1ps
module axi_wr_packet_fifo (
   input  logic                     axi_aclk,
   input  logic                     reset,
   // upstream write address
   input  axi_wr_fifo_pkg::aw_cmd_t s_aw,
   input  logic                     s_awvalid,
   output logic                     s_awready,
   // upstream write data
   input  axi_wr_fifo_pkg::w_beat_t s_w,
   input  logic                     s_wvalid,
   output logic                     s_wready,
   // upstream response
   output axi_wr_fifo_pkg::b_rsp_t  s_b,
   output logic                     s_bvalid,
   input  logic                     s_bready,
   // downstream write address
   output axi_wr_fifo_pkg::aw_cmd_t m_aw,
   output logic                     m_awvalid,
   input  logic                     m_awready,
   // downstream write data
   output axi_wr_fifo_pkg::w_beat_t m_w,
   output logic                     m_wvalid,
   input  logic                     m_wready,
   // downstream response
   input  axi_wr_fifo_pkg::b_rsp_t  m_b,
   input  logic                     m_bvalid,
   output logic                     m_bready
);
   import axi_wr_fifo_pkg::*;

   // queued address toward the release FSM
   aw_cmd_t q_aw;
   logic    q_awvalid;
   logic    q_awready;

   // store read side
   w_beat_t rd_beat;
   logic    rd_valid;
   logic    rd_ready;
   logic    pkt_avail;

   // address queue
   sync_fifo #(
      .WIDTH ($bits(aw_cmd_t)),
      .DEPTH (AW_DEPTH)
   ) aw_queue (
      .axi_aclk   (axi_aclk),
      .reset      (reset),
      .push_data  (s_aw),
      .push_valid (s_awvalid),
      .push_ready (s_awready),
      .pop_data   (q_aw),
      .pop_valid  (q_awvalid),
      .pop_ready  (q_awready)
   );

   // whole bursts collected here
   wr_packet_store i_wr_packet_store (
      .axi_aclk  (axi_aclk),
      .reset     (reset),
      .s_w       (s_w),
      .s_wvalid  (s_wvalid),
      .s_wready  (s_wready),
      .rd_beat   (rd_beat),
      .rd_valid  (rd_valid),
      .rd_ready  (rd_ready),
      .pkt_avail (pkt_avail)
   );

   // pairs each address with its stored burst
   aw_release_gen i_aw_release_gen (
      .axi_aclk  (axi_aclk),
      .reset     (reset),
      .q_aw      (q_aw),
      .q_awvalid (q_awvalid),
      .q_awready (q_awready),
      .pkt_avail (pkt_avail),
      .rd_beat   (rd_beat),
      .rd_valid  (rd_valid),
      .rd_ready  (rd_ready),
      .m_aw      (m_aw),
      .m_awvalid (m_awvalid),
      .m_awready (m_awready),
      .m_w       (m_w),
      .m_wvalid  (m_wvalid),
      .m_wready  (m_wready)
   );

   // response return path
   sync_fifo #(
      .WIDTH ($bits(b_rsp_t)),
      .DEPTH (AW_DEPTH)
   ) b_queue (
      .axi_aclk   (axi_aclk),
      .reset      (reset),
      .push_data  (m_b),
      .push_valid (m_bvalid),
      .push_ready (m_bready),
      .pop_data   (s_b),
      .pop_valid  (s_bvalid),
      .pop_ready  (s_bready)
   );

endmodule

// File: test/tb_axi_wr_checks.svh
// Expected values and compare tasks
`ifndef TB_AXI_WR_CHECKS_SVH
`define TB_AXI_WR_CHECKS_SVH

// expected transfers in send order
aw_cmd_t exp_aw [$];
w_beat_t exp_w [$];
b_rsp_t  exp_b [$];

// downstream address command
task automatic check_aw(input string name, input aw_cmd_t expected, input aw_cmd_t actual);
   if (actual !== expected) begin
      $display("mismatch at time %0t: %s expected %h actual %h", $time, name, expected, actual);
      end_with_failure();
   end
endtask

// downstream data beat, last flag included
task automatic check_w(input string name, input w_beat_t expected, input w_beat_t actual);
   if (actual !== expected) begin
      $display("mismatch at time %0t: %s expected %h actual %h", $time, name, expected, actual);
      end_with_failure();
   end
endtask

// upstream response
task automatic check_b(input string name, input b_rsp_t expected, input b_rsp_t actual);
   if (actual !== expected) begin
      $display("mismatch at time %0t: %s expected %h actual %h", $time, name, expected, actual);
      end_with_failure();
   end
endtask

// single valid or ready flag
task automatic check_bit(input string name, input logic expected, input logic actual);
   if (actual !== expected) begin
      $display("mismatch at time %0t: %s expected %b actual %b", $time, name, expected, actual);
      end_with_failure();
   end
endtask

`endif

// File: test/tb_axi_wr_packet_fifo.sv
// AXI write packet FIFO testbench
`timescale 1ns/1ps
module tb_axi_wr_packet_fifo;
   import axi_wr_fifo_pkg::*;

   // length of the precomputed ready stall pattern
   localparam int STALL_N = 256;

   logic    axi_aclk = 1'b0;
   logic    reset;
   aw_cmd_t s_aw;
   logic    s_awvalid;
   logic    s_awready;
   w_beat_t s_w;
   logic    s_wvalid;
   logic    s_wready;
   b_rsp_t  s_b;
   logic    s_bvalid;
   logic    s_bready;
   aw_cmd_t m_aw;
   logic    m_awvalid;
   logic    m_awready;
   w_beat_t m_w;
   logic    m_wvalid;
   logic    m_wready;
   b_rsp_t  m_b;
   logic    m_bvalid;
   logic    m_bready;

   int      seed = 32'hc1e4_9dcf;
   int      burst_len [8];
   int      cycle_cnt;
   int      cycle_limit;
   // beats the monitor still allows behind seen addresses
   int      beats_granted = 0;
   logic    stall_on;
   logic    aw_stall [STALL_N];
   logic    w_stall [STALL_N];
   // beats waiting to be driven upstream
   w_beat_t tx_w [$];

   always #5 axi_aclk = ~axi_aclk;

   axi_wr_packet_fifo i_axi_wr_packet_fifo (.*);

   task automatic end_with_failure();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic report_failure(input string why);
      $display("error at time %0t: %s", $time, why);
      end_with_failure();
   endtask

   `include "tb_axi_wr_checks.svh"

   // inputs change 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge axi_aclk);
      #1;
   endtask

   function automatic aw_cmd_t rand_cmd(input int beats);
      aw_cmd_t cmd;
      cmd.id   = ID_W'($random(seed));
      cmd.addr = ADDR_W'($random(seed));
      cmd.len  = LEN_W'(beats - 1);
      return cmd;
   endfunction

   function automatic b_rsp_t rand_rsp();
      b_rsp_t rsp;
      rsp.id   = ID_W'($random(seed));
      rsp.resp = bresp_e'(2'($random(seed)));
      return rsp;
   endfunction

   // upstream master address side
   task automatic send_aw(input aw_cmd_t cmd);
      exp_aw.push_back(cmd);
      s_aw      = cmd;
      s_awvalid = 1'b1;
      @(negedge axi_aclk);
      while (!s_awready) @(negedge axi_aclk);
      next_cycle();
      s_awvalid = 1'b0;
   endtask

   // one burst of random data with last on the final beat
   task automatic queue_beats(input int n);
      w_beat_t beat;
      for (int i = 0; i < n; i++) begin
         beat.data = DATA_W'($random(seed));
         beat.last = (i == n - 1);
         tx_w.push_back(beat);
         exp_w.push_back(beat);
      end
   endtask

   task automatic send_next_beat();
      s_w      = tx_w.pop_front();
      s_wvalid = 1'b1;
      @(negedge axi_aclk);
      while (!s_wready) @(negedge axi_aclk);
      next_cycle();
      s_wvalid = 1'b0;
   endtask

   task automatic send_burst(input aw_cmd_t cmd);
      send_aw(cmd);
      queue_beats(int'(cmd.len) + 1);
      repeat (int'(cmd.len) + 1) send_next_beat();
   endtask

   // downstream slave response
   task automatic send_b(input b_rsp_t rsp);
      exp_b.push_back(rsp);
      m_b      = rsp;
      m_bvalid = 1'b1;
      @(negedge axi_aclk);
      while (!m_bready) @(negedge axi_aclk);
      next_cycle();
      m_bvalid = 1'b0;
   endtask

   // until every expected transfer has been seen
   task automatic wait_drain();
      do begin
         @(posedge axi_aclk);
      end while (exp_aw.size() != 0 || exp_w.size() != 0 || exp_b.size() != 0);
      #1;
   endtask

   task automatic test_single_burst();
      send_burst(rand_cmd(4));
      wait_drain();
   endtask

   // last beat withheld so no address may leave
   task automatic test_hold_back();
      send_aw(rand_cmd(5));
      queue_beats(5);
      repeat (4) send_next_beat();
      repeat (20) begin
         @(negedge axi_aclk);
         check_bit("m_awvalid", 1'b0, m_awvalid);
      end
      next_cycle();
      send_next_beat();
      wait_drain();
   endtask

   task automatic test_stall_stream();
      @(negedge axi_aclk);
      stall_on = 1'b1;
      next_cycle();
      for (int i = 0; i < 8; i++) begin
         send_burst(rand_cmd(burst_len[i]));
      end
      wait_drain();
      @(negedge axi_aclk);
      stall_on = 1'b0;
      next_cycle();
   endtask

   // full burst stored before its address shows up
   task automatic test_data_first();
      aw_cmd_t cmd;
      cmd = rand_cmd(4);
      queue_beats(4);
      repeat (4) send_next_beat();
      repeat (10) next_cycle();
      send_aw(cmd);
      wait_drain();
   endtask

   task automatic test_resp_and_full();
      aw_cmd_t extra;
      // b_queue fills while upstream is stalled
      s_bready = 1'b0;
      for (int i = 0; i < AW_DEPTH; i++) begin
         send_b(rand_rsp());
      end
      @(negedge axi_aclk);
      check_bit("m_bready", 1'b0, m_bready);
      next_cycle();
      fork
         begin
            send_b(rand_rsp());
            send_b(rand_rsp());
         end
         begin
            repeat (6) begin
               @(negedge axi_aclk);
               check_bit("m_bready", 1'b0, m_bready);
            end
            next_cycle();
            s_bready = 1'b1;
         end
      join
      wait_drain();
      // addresses with no data fill aw_queue
      for (int i = 0; i < AW_DEPTH; i++) begin
         send_aw(rand_cmd(1));
      end
      extra = rand_cmd(1);
      fork
         send_aw(extra);
         begin
            repeat (5) begin
               @(negedge axi_aclk);
               check_bit("s_awready", 1'b0, s_awready);
            end
            next_cycle();
            // one single beat burst per queued address
            for (int i = 0; i <= AW_DEPTH; i++) begin
               queue_beats(1);
               send_next_beat();
            end
         end
      join
      wait_drain();
   endtask

   // downstream and response monitor sampled mid cycle
   always @(negedge axi_aclk) begin
      if (!reset) begin
         // data only behind a completed address handshake
         if (m_wvalid && beats_granted == 0) begin
            report_failure("m_wvalid raised with no address handshake ahead of it");
         end
         if (m_awvalid && m_awready) begin
            if (exp_aw.size() == 0) begin
               report_failure("address on m_aw that was never sent upstream");
            end else begin
               check_aw("m_aw", exp_aw.pop_front(), m_aw);
               beats_granted += int'(m_aw.len) + 1;
            end
         end
         if (m_wvalid && m_wready) begin
            if (exp_w.size() == 0) begin
               report_failure("data beat on m_w that was never sent upstream");
            end else begin
               check_w("m_w", exp_w.pop_front(), m_w);
               beats_granted--;
            end
         end
         if (s_bvalid && s_bready) begin
            if (exp_b.size() == 0) begin
               report_failure("response on s_b that was never sent downstream");
            end else begin
               check_b("s_b", exp_b.pop_front(), s_b);
            end
         end
      end
   end

   // downstream ready stalls active in the stall test only
   initial begin
      m_awready = 1'b1;
      m_wready  = 1'b1;
      forever begin
         next_cycle();
         m_awready = !(stall_on && aw_stall[cycle_cnt % STALL_N]);
         m_wready  = !(stall_on && w_stall[cycle_cnt % STALL_N]);
      end
   end

   // run limit
   initial begin
      cycle_cnt = 0;
      forever begin
         @(posedge axi_aclk);
         cycle_cnt++;
         if (cycle_cnt > cycle_limit) begin
            report_failure($sformatf("timeout, run not done after %0d cycles", cycle_limit));
         end
      end
   end

   initial begin
      reset     = 1'b1;
      s_aw      = '0;
      s_awvalid = 1'b0;
      s_w       = '0;
      s_wvalid  = 1'b0;
      s_bready  = 1'b1;
      m_b       = '0;
      m_bvalid  = 1'b0;
      stall_on  = 1'b0;
      // roughly one low ready in four
      for (int i = 0; i < STALL_N; i++) begin
         aw_stall[i] = ($unsigned($random(seed)) % 4) == 0;
         w_stall[i]  = ($unsigned($random(seed)) % 4) == 0;
      end
      // fixed tests send 26 addresses and beats
      cycle_limit = 26;
      for (int i = 0; i < 8; i++) begin
         burst_len[i] = 1 + int'($unsigned($random(seed)) % 16);
         cycle_limit += burst_len[i] + 1;
      end
      cycle_limit = 4 * cycle_limit + 200;
      repeat (10) @(posedge axi_aclk);
      #1;
      reset = 1'b0;
      // idle values after reset
      @(negedge axi_aclk);
      check_bit("m_awvalid", 1'b0, m_awvalid);
      check_bit("m_wvalid", 1'b0, m_wvalid);
      check_bit("s_bvalid", 1'b0, s_bvalid);
      check_bit("s_awready", 1'b1, s_awready);
      check_bit("s_wready", 1'b1, s_wready);
      check_bit("m_bready", 1'b1, m_bready);
      next_cycle();
      test_single_burst();
      test_hold_back();
      test_stall_stream();
      test_data_first();
      test_resp_and_full();
      $display("sim passed");
      $finish;
   end

endmodule

// File: axi_wr_packet_fifo.f
+incdir+test
src/axi_wr_fifo_pkg.sv
src/sync_fifo.sv
src/wr_packet_store.sv
src/aw_release_gen.sv
src/axi_wr_packet_fifo.sv
test/tb_axi_wr_packet_fifo.sv

// File: Makefile
# Verilator build and run for the AXI write packet FIFO
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f axi_wr_packet_fifo.f \
		--top-module tb_axi_wr_packet_fifo -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1; cat $(LOG)
	grep -qx "sim passed" $(LOG)

lint:
	verilator --lint-only --timing -f axi_wr_packet_fifo.f \
		--top-module axi_wr_packet_fifo

clean:
	rm -rf obj_dir $(LOG)
